// File: Bender.yml
package:
  name: bpu

sources:
  - include_dirs:
      - hw
    files:
      - hw/bpu_pkg.sv
      - hw/ring_stack.sv
      - hw/branch_history_table.sv
      - hw/next_pc_select.sv
      - hw/branch_predictor.sv

  - target: simulation
    include_dirs:
      - hw
    files:
      - testbench/bpu_chk.sv
      - testbench/bpu_tb.sv

// File: build.f
+incdir+hw
hw/bpu_pkg.sv
hw/ring_stack.sv
hw/branch_history_table.sv
hw/next_pc_select.sv
hw/branch_predictor.sv
testbench/bpu_chk.sv
testbench/bpu_tb.sv

// File: hw/bpu_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizes for the branch prediction front end
// include in every rtl file that needs widths or depths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef BPU_PARAMS_SVH
`define BPU_PARAMS_SVH

// pc and data path width
`define BPU_XLEN 32

// return address stack address bits (8 entries)
`define BPU_RAS_AW 3

// history table index bits (64 counters)
// index is taken from pc bit 2 upward
`define BPU_BHT_AW 6

`endif

// File: hw/bpu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types of the branch prediction front end
// predecode class and counter states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package bpu_pkg;

	// predecode class of the fetched instruction
	typedef enum logic [2:0] {
		cls_none = 3'd0,	// no control flow
		cls_cond = 3'd1,	// conditional branch
		cls_jal  = 3'd2,	// direct jump without link
		cls_call = 3'd3,	// direct jump with link
		cls_ret  = 3'd4		// return through link register
	} instr_class_e;

	// 2-bit saturating counter state
	// msb set means predict taken
	typedef enum logic [1:0] {
		ctr_strong_nt = 2'b00,
		ctr_weak_nt   = 2'b01,
		ctr_weak_t    = 2'b10,
		ctr_strong_t  = 2'b11
	} counter_e;

endpackage

// File: hw/branch_history_table.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pc-indexed table of 2-bit saturating counters
// lookup is combinational, training lands at the next clock edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "bpu_params.svh"

module branch_history_table
	import bpu_pkg::*;
#(
	parameter int AW = `BPU_BHT_AW
) (
	input  logic                 CLK,
	input  logic                 reset,
	input  logic [`BPU_XLEN-1:0] lookup_pc,
	output logic                 taken,
	input  logic                 update_valid,
	input  logic [`BPU_XLEN-1:0] update_pc,
	input  logic                 update_taken
);

	localparam int entries = 2**AW;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// counter step
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// one state toward the outcome, both ends saturate
	function automatic counter_e step_counter(input counter_e cur, input logic tk);
		counter_e nxt;
		nxt = cur;
		unique case (cur)
			ctr_strong_nt: nxt = tk ? ctr_weak_nt : ctr_strong_nt;
			ctr_weak_nt:   nxt = tk ? ctr_weak_t  : ctr_strong_nt;
			ctr_weak_t:    nxt = tk ? ctr_strong_t : ctr_weak_nt;
			ctr_strong_t:  nxt = tk ? ctr_strong_t : ctr_weak_t;
			default:       nxt = cur;
		endcase
		return nxt;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// table and indexing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	counter_e      ctr_tbl [entries];	// one counter per index
	logic [AW-1:0] lookup_idx;
	logic [AW-1:0] update_idx;
	counter_e      lookup_ctr;
	counter_e      update_ctr;			// counter before training
	counter_e      trained_ctr;			// counter after training

	assign lookup_idx = lookup_pc[AW+1:2];	// word aligned, skip bits 1:0
	assign update_idx = update_pc[AW+1:2];

	// lookup path
	assign lookup_ctr = ctr_tbl[lookup_idx];
	assign taken      = lookup_ctr[1];	// msb is the taken half

	// training path
	assign update_ctr  = ctr_tbl[update_idx];
	assign trained_ctr = step_counter(update_ctr, update_taken);

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < entries; i++) begin
				ctr_tbl[i] <= ctr_weak_nt;	// start weakly not taken
			end
		end else if (update_valid) begin
			ctr_tbl[update_idx] <= trained_ctr;
		end
	end

endmodule

// File: hw/branch_predictor.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top level of the branch prediction front end
// return stack and counter table side by side, joined by the selector
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "bpu_params.svh"

module branch_predictor
	import bpu_pkg::*;
(
	input  logic                 CLK,
	input  logic                 reset,
	input  logic                 fetch_valid,
	input  logic [`BPU_XLEN-1:0] fetch_pc,
	input  instr_class_e         fetch_class,
	input  logic [`BPU_XLEN-1:0] fetch_imm,
	input  logic                 flush,
	input  logic                 update_valid,
	input  logic [`BPU_XLEN-1:0] update_pc,
	input  logic                 update_taken,
	output logic [`BPU_XLEN-1:0] next_pc,
	output logic                 pred_taken
);

	// selector to stack
	logic                 ras_push;
	logic                 ras_pop;
	logic [`BPU_XLEN-1:0] ras_push_data;
	// stack to selector
	logic [`BPU_XLEN-1:0] ras_pop_data;
	logic                 ras_empty;
	// table to selector
	logic                 bht_taken;

	ring_stack #(
		.DW(`BPU_XLEN),
		.AW(`BPU_RAS_AW)
	) ras_i (
		.CLK       (CLK),
		.reset     (reset),
		.flush     (flush),				// flush reaches the stack only
		.push      (ras_push),
		.pop       (ras_pop),
		.push_data (ras_push_data),
		.pop_data  (ras_pop_data),
		.empty     (ras_empty)
	);

	branch_history_table #(
		.AW(`BPU_BHT_AW)
	) bht_i (
		.CLK          (CLK),
		.reset        (reset),
		.lookup_pc    (fetch_pc),		// looked up with the fetch pc
		.taken        (bht_taken),
		.update_valid (update_valid),
		.update_pc    (update_pc),
		.update_taken (update_taken)
	);

	next_pc_select sel_i (
		.fetch_valid   (fetch_valid),
		.fetch_pc      (fetch_pc),
		.fetch_class   (fetch_class),
		.fetch_imm     (fetch_imm),
		.bht_taken     (bht_taken),
		.ras_pop_data  (ras_pop_data),
		.ras_empty     (ras_empty),
		.ras_push      (ras_push),
		.ras_pop       (ras_pop),
		.ras_push_data (ras_push_data),
		.next_pc       (next_pc),
		.pred_taken    (pred_taken)
	);

endmodule

// File: hw/next_pc_select.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// class decode and next pc choice
// drives the stack strobes and merges stack and counter predictions
// purely combinational
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "bpu_params.svh"

module next_pc_select
	import bpu_pkg::*;
(
	input  logic                 fetch_valid,
	input  logic [`BPU_XLEN-1:0] fetch_pc,
	input  instr_class_e         fetch_class,
	input  logic [`BPU_XLEN-1:0] fetch_imm,
	input  logic                 bht_taken,
	input  logic [`BPU_XLEN-1:0] ras_pop_data,
	input  logic                 ras_empty,
	output logic                 ras_push,
	output logic                 ras_pop,
	output logic [`BPU_XLEN-1:0] ras_push_data,
	output logic [`BPU_XLEN-1:0] next_pc,
	output logic                 pred_taken
);

	// instruction size in bytes at full pc width
	localparam logic [`BPU_XLEN-1:0] instr_bytes = {{(`BPU_XLEN-3){1'b0}}, 3'd4};

	logic                 is_cond;
	logic                 is_jump;		// jal or call
	logic                 is_call;
	logic                 is_ret;
	logic [`BPU_XLEN-1:0] seq_pc;		// fall-through pc
	logic [`BPU_XLEN-1:0] tgt_pc;		// pc relative target

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// class decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		is_cond = 1'b0;
		is_jump = 1'b0;
		is_call = 1'b0;
		is_ret  = 1'b0;
		if (fetch_valid) begin			// idle fetch decodes as nothing
			case (fetch_class)
				cls_cond: is_cond = 1'b1;
				cls_jal:  is_jump = 1'b1;
				cls_call: begin
					is_jump = 1'b1;
					is_call = 1'b1;
				end
				cls_ret:  is_ret = 1'b1;
				default:  ;					// cls_none falls through
			endcase
		end
	end

	assign seq_pc = fetch_pc + instr_bytes;
	assign tgt_pc = fetch_pc + fetch_imm;

	// stack strobes
	assign ras_push      = is_call;
	assign ras_pop       = is_ret;
	assign ras_push_data = seq_pc;		// link address of the call

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// next pc choice
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		next_pc    = seq_pc;				// default is fall through
		pred_taken = 1'b0;
		if (is_jump) begin
			next_pc    = tgt_pc;			// direct jumps always taken
			pred_taken = 1'b1;
		end else if (is_cond && bht_taken) begin
			next_pc    = tgt_pc;
			pred_taken = 1'b1;
		end else if (is_ret && !ras_empty) begin
			next_pc    = ras_pop_data;		// top of stack
			pred_taken = 1'b1;
		end
	end

endmodule

// File: hw/ring_stack.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ring-shaped return address stack
// push on call and pop on return, oldest entry lost when full
// flush empties the stack at the next clock edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "bpu_params.svh"

module ring_stack #(
	parameter int DW = `BPU_XLEN,
	parameter int AW = `BPU_RAS_AW
) (
	input  logic          CLK,
	input  logic          reset,
	input  logic          flush,
	input  logic          push,
	input  logic          pop,
	input  logic [DW-1:0] push_data,
	output logic [DW-1:0] pop_data,
	output logic          empty
);

	localparam int depth = 2**AW;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pointers and storage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	logic [AW:0]   top_ptr;			// next free slot, extra wrap bit
	logic [AW:0]   btm_ptr;			// oldest valid slot, extra wrap bit
	logic [AW:0]   top_nxt;
	logic [AW:0]   btm_nxt;
	logic          full;
	logic          pop_ok;			// pop that actually removes an entry
	logic [AW-1:0] wr_addr;
	logic [AW-1:0] rd_addr;
	logic [DW-1:0] mem [depth];

	assign empty  = (top_ptr == btm_ptr);
	assign full   = (top_ptr[AW-1:0] == btm_ptr[AW-1:0]) &
	                (top_ptr[AW] != btm_ptr[AW]);	// same slot, different lap
	assign pop_ok = pop & ~empty;		// pop on empty is dropped

	assign wr_addr = top_ptr[AW-1:0];
	assign rd_addr = top_ptr[AW-1:0] - AW'(1);	// entry just below top

	assign pop_data = mem[rd_addr];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pointer update
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		top_nxt = top_ptr;
		btm_nxt = btm_ptr;
		if (flush) begin				// flush beats any push
			top_nxt = '0;
			btm_nxt = '0;
		end else if (push) begin
			top_nxt = top_ptr + (AW+1)'(1);
			if (full) begin
				btm_nxt = btm_ptr + (AW+1)'(1);	// drop the oldest return address
			end
		end else if (pop_ok) begin
			top_nxt = top_ptr - (AW+1)'(1);
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			top_ptr <= '0;
			btm_ptr <= '0;
		end else begin
			top_ptr <= top_nxt;
			btm_ptr <= btm_nxt;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// entry write
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK) begin
		if (push && !flush) begin
			mem[wr_addr] <= push_data;	// overwrites oldest slot when full
		end
	end

endmodule

// File: testbench/bpu_chk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bound checker for the branch predictor
// shadow stack and counters built from the dut inputs only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "bpu_params.svh"

module bpu_chk
	import bpu_pkg::*;
(
	input logic                 CLK,
	input logic                 reset,
	input logic                 fetch_valid,
	input logic [`BPU_XLEN-1:0] fetch_pc,
	input instr_class_e         fetch_class,
	input logic [`BPU_XLEN-1:0] fetch_imm,
	input logic                 flush,
	input logic                 update_valid,
	input logic [`BPU_XLEN-1:0] update_pc,
	input logic                 update_taken,
	input logic [`BPU_XLEN-1:0] next_pc,
	input logic                 pred_taken
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ras_n = 1 << `BPU_RAS_AW;
	localparam int bht_n = 1 << `BPU_BHT_AW;

	int                     errors = 0;		// read by the testbench
	logic [`BPU_XLEN-1:0]   sh_stack [ras_n];	// ring copy of the return stack
	logic [`BPU_RAS_AW-1:0] sh_ptr;			// next free slot, wraps
	int                     sh_depth;		// valid entries, capped at ras_n
	logic [1:0]             sh_ctr [bht_n];	// 0 strong not taken .. 3 strong taken
	logic [`BPU_BHT_AW-1:0] fetch_idx;
	logic [`BPU_BHT_AW-1:0] upd_idx;
	logic [`BPU_XLEN-1:0]   exp_pc;
	logic                   exp_taken;

	assign fetch_idx = fetch_pc[`BPU_BHT_AW+1:2];
	assign upd_idx   = update_pc[`BPU_BHT_AW+1:2];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// shadow models
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(posedge CLK) begin
		if (reset) begin
			sh_ptr   <= '0;
			sh_depth <= 0;
			for (int i = 0; i < bht_n; i++) begin
				sh_ctr[i] <= 2'd1;			// weakly not taken
			end
		end else begin
			if (flush) begin				// flush drops a same-cycle call
				sh_ptr   <= '0;
				sh_depth <= 0;
			end else if (fetch_valid && fetch_class == cls_call) begin
				sh_stack[sh_ptr] <= fetch_pc + 32'd4;
				sh_ptr           <= sh_ptr + 1'b1;
				if (sh_depth < ras_n) begin
					sh_depth <= sh_depth + 1;	// oldest lost once full
				end
			end else if (fetch_valid && fetch_class == cls_ret && sh_depth > 0) begin
				sh_ptr   <= sh_ptr - 1'b1;
				sh_depth <= sh_depth - 1;
			end
			if (update_valid) begin
				if (update_taken && sh_ctr[upd_idx] != 2'd3) begin
					sh_ctr[upd_idx] <= sh_ctr[upd_idx] + 2'd1;
				end else if (!update_taken && sh_ctr[upd_idx] != 2'd0) begin
					sh_ctr[upd_idx] <= sh_ctr[upd_idx] - 2'd1;
				end
			end
		end
	end

	// expected prediction from the class rules
	always_comb begin
		exp_pc    = fetch_pc + 32'd4;
		exp_taken = 1'b0;
		if (fetch_valid) begin
			case (fetch_class)
				cls_jal, cls_call: begin
					exp_pc    = fetch_pc + fetch_imm;
					exp_taken = 1'b1;
				end
				cls_cond: begin
					if (sh_ctr[fetch_idx][1]) begin
						exp_pc    = fetch_pc + fetch_imm;
						exp_taken = 1'b1;
					end
				end
				cls_ret: begin
					if (sh_depth != 0) begin
						exp_pc    = sh_stack[sh_ptr - 1'b1];	// newest entry
						exp_taken = 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// assertions
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	a_next_pc: assert property (@(posedge CLK) disable iff (reset) next_pc == exp_pc)
		else begin
			$error("Fail %0t next_pc expected %h actual %h", $time,
				$sampled(exp_pc), $sampled(next_pc));
			errors++;
		end

	a_pred_taken: assert property (@(posedge CLK) disable iff (reset) pred_taken == exp_taken)
		else begin
			$error("Fail %0t pred_taken expected %b actual %b", $time,
				$sampled(exp_taken), $sampled(pred_taken));
			errors++;
		end

endmodule

bind branch_predictor bpu_chk chk_i (.*);

// File: testbench/bpu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the branch predictor
// drives fetch, flush and update sequences, the bound checker judges
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "bpu_params.svh"

module bpu_tb
	import bpu_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int wait_limit = 50;		// cycles per wait loop
	localparam logic [`BPU_XLEN-1:0] alias_step = 1 << (`BPU_BHT_AW + 2);

	logic                 CLK;
	logic                 reset;
	logic                 fetch_valid;
	logic [`BPU_XLEN-1:0] fetch_pc;
	instr_class_e         fetch_class;
	logic [`BPU_XLEN-1:0] fetch_imm;
	logic                 flush;
	logic                 update_valid;
	logic [`BPU_XLEN-1:0] update_pc;
	logic                 update_taken;
	logic [`BPU_XLEN-1:0] next_pc;
	logic                 pred_taken;
	int                   seed;
	int                   tb_errors;
	int                   chk_errors;
	logic [`BPU_XLEN-1:0] train_pc [4];

	branch_predictor dut_i (.*);

	always #10 CLK = ~CLK;				// 20 ns period

	// word aligned random value
	function automatic logic [`BPU_XLEN-1:0] rand_word();
		return $random(seed) & 32'hffff_fffc;
	endfunction

	// one input cycle, applied on the falling edge
	task automatic drive(input logic valid, input instr_class_e cls,
		input logic [`BPU_XLEN-1:0] pc, input logic [`BPU_XLEN-1:0] imm,
		input logic flsh, input logic upd, input logic [`BPU_XLEN-1:0] upc,
		input logic utk);
		@(negedge CLK);
		fetch_valid  = valid;
		fetch_class  = cls;
		fetch_pc     = pc;
		fetch_imm    = imm;
		flush        = flsh;
		update_valid = upd;
		update_pc    = upc;
		update_taken = utk;
	endtask

	task automatic fetch(input instr_class_e cls, input logic [`BPU_XLEN-1:0] pc);
		drive(1'b1, cls, pc, rand_word(), 1'b0, 1'b0, '0, 1'b0);
	endtask

	// reset for 10 cycles, a conditional fetch lands in the first free cycle
	task automatic apply_reset();
		@(negedge CLK);
		reset        = 1'b1;
		fetch_valid  = 1'b0;
		flush        = 1'b0;
		update_valid = 1'b0;
		repeat (10) @(posedge CLK);
		@(negedge CLK);
		reset       = 1'b0;
		fetch_valid = 1'b1;
		fetch_class = cls_cond;			// counters must read not taken
		fetch_pc    = rand_word();
	endtask

	// returns until the stack runs dry and the prediction falls through
	task automatic drain_returns();
		int cnt;
		cnt = 0;
		fetch(cls_ret, rand_word());
		#5;								// mid low phase, outputs settled
		while (pred_taken && cnt < wait_limit) begin
			fetch(cls_ret, rand_word());
			#5;
			cnt++;
		end
		if (cnt >= wait_limit) begin
			$display("timeout waiting for the return stack to drain");
			tb_errors++;
		end
	endtask

	// random training, then both saturation ends through an aliasing pc
	task automatic train_index(input logic [`BPU_XLEN-1:0] pc);
		logic [`BPU_XLEN-1:0] alias_pc;
		alias_pc = pc ^ alias_step;		// same index bits, other tag
		repeat (8) drive(1'b1, cls_cond, pc, rand_word(), 1'b0, 1'b1, pc, 1'($random(seed)));
		repeat (4) drive(1'b1, cls_cond, alias_pc, rand_word(), 1'b0, 1'b1, pc, 1'b1);
		fetch(cls_cond, alias_pc);
		repeat (4) drive(1'b1, cls_cond, pc, rand_word(), 1'b0, 1'b1, alias_pc, 1'b0);
		fetch(cls_cond, pc);
	endtask

	initial begin
		CLK          = 1'b0;
		reset        = 1'b1;
		fetch_valid  = 1'b0;
		fetch_pc     = '0;
		fetch_class  = cls_none;
		fetch_imm    = '0;
		flush        = 1'b0;
		update_valid = 1'b0;
		update_pc    = '0;
		update_taken = 1'b0;
		seed         = 32'h4be0;
		tb_errors    = 0;

		apply_reset();
		fetch(cls_ret, rand_word());	// empty stack right after reset

		// sequential and direct paths
		for (int i = 0; i < 30; i++) begin
			case ($unsigned($random(seed)) % 3)
				0:       drive(1'b0, cls_jal, rand_word(), rand_word(), 1'b0, 1'b0, '0, 1'b0);
				1:       fetch(cls_none, rand_word());
				default: fetch(cls_jal, rand_word());
			endcase
		end

		// nested calls, matching returns, one extra on empty
		for (int n = 1; n <= 5; n++) begin
			repeat (n) fetch(cls_call, rand_word());
			repeat (n) fetch(cls_ret, rand_word());
			fetch(cls_ret, rand_word());
		end

		// overflow, 10 calls on 8 entries
		repeat (10) fetch(cls_call, rand_word());
		drain_returns();
		fetch(cls_ret, rand_word());

		// flush alone, then flush with a call
		repeat (3) fetch(cls_call, rand_word());
		drive(1'b0, cls_none, rand_word(), '0, 1'b1, 1'b0, '0, 1'b0);
		fetch(cls_ret, rand_word());
		drive(1'b1, cls_call, rand_word(), rand_word(), 1'b1, 1'b0, '0, 1'b0);
		fetch(cls_ret, rand_word());

		// counter training
		for (int k = 0; k < 4; k++) begin
			train_pc[k] = rand_word();
			train_index(train_pc[k]);
		end

		// reset state again, trained pcs read weakly not taken
		apply_reset();
		fetch(cls_ret, rand_word());
		for (int k = 0; k < 4; k++) begin
			fetch(cls_cond, train_pc[k]);
		end
		drive(1'b0, cls_none, '0, '0, 1'b0, 1'b0, '0, 1'b0);
		repeat (2) @(negedge CLK);

		chk_errors = dut_i.chk_i.errors;
		$display("checker errors: %0d, testbench errors: %0d", chk_errors, tb_errors);
		if (chk_errors + tb_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
